/* hw/exec_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Link register and program counter
`define R14 4'd14
`define R15 4'd15

// Undefined instruction vector, word address
`define EXC_UNDEF_VECTOR 30'd1

// What a read of R15 sees past the instruction address
`define PC_AHEAD 32'd8

`endif

/* hw/exec_pkg.sv */
package exec_pkg;

	typedef logic [31:0] word;
	typedef logic [29:0] ptr;      // Word address
	typedef logic [3:0]  reg_num;
	typedef logic [15:0] reg_list;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	// ARM data-processing opcode order
	typedef enum logic [3:0] {
		ALU_AND, ALU_EOR, ALU_SUB, ALU_RSB,
		ALU_ADD, ALU_ADC, ALU_SBC, ALU_RSC,
		ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN,
		ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN
	} alu_op;

	typedef enum logic [1:0] {
		SHIFT_LSL,
		SHIFT_LSR,
		SHIFT_ASR,
		SHIFT_ROR
	} shift_kind;

	typedef struct packed {
		shift_kind  kind;
		logic [7:0] amount;
		logic       c_in;
	} shifter_control;

	typedef enum logic [2:0] {
		ISSUE,
		EXECUTE,
		REG_SHIFT,
		TRANSFER,
		BASE_WRITEBACK,
		EXCEPTION
	} ctrl_cycle;

	typedef struct packed {
		logic        execute;
		logic        undefined;
		logic        is_branch;
		logic [23:0] offset;       // Branch offset in words
		alu_op       op;
		reg_num      rn;
		reg_num      rd;
		reg_num      rm;
		reg_num      rs;
		logic        snd_is_imm;
		logic [11:0] imm12;
		logic        shift_by_reg;
		shift_kind   shift;
		logic [4:0]  shift_imm;
		logic        update_flags;
		logic        writeback;
		logic        ldst_enable;
		logic        load;
		logic        pre_indexed;
		logic        increment;
		logic        base_writeback;
		logic        block;        // LDM/STM
		reg_list     regs;
	} insn_decode;

	typedef struct packed {
		ptr   addr;
		word  wdata;
		logic write;
	} mem_req;

	typedef struct packed {
		logic   valid;
		reg_num rd;
		word    value;
	} wb_port;

endpackage

/* hw/barrel_shifter.sv */
module barrel_shifter (
	input  exec_pkg::word            value,
	input  exec_pkg::shifter_control ctrl,
	output exec_pkg::word            q,
	output logic                     c_out
);
	import exec_pkg::*;

	logic [4:0]  amt;
	logic [63:0] rot;
	logic        in_range;

	assign amt = ctrl.amount[4:0];
	assign in_range = ctrl.amount < 8'd32;
	assign rot = {value, value} >> amt;

	always_comb begin
		q = value;
		c_out = ctrl.c_in;  // Amount 0 keeps the carry

		if (ctrl.amount != 8'd0) begin
			unique case (ctrl.kind)
				SHIFT_LSL: begin
					if (in_range) begin
						q = value << amt;
						c_out = value[32 - amt];
					end else begin
						q = '0;
						c_out = ctrl.amount == 8'd32 ? value[0] : 1'b0;
					end
				end
				SHIFT_LSR: begin
					if (in_range) begin
						q = value >> amt;
						c_out = value[amt - 1];
					end else begin
						q = '0;
						c_out = ctrl.amount == 8'd32 ? value[31] : 1'b0;
					end
				end
				SHIFT_ASR: begin
					if (in_range) begin
						q = $signed(value) >>> amt;
						c_out = value[amt - 1];
					end else begin
						q = {32{value[31]}};  // Sign fill
						c_out = value[31];
					end
				end
				SHIFT_ROR: begin
					q = rot[31:0];
					c_out = rot[31];  // Multiple of 32 gives bit 31
				end
			endcase
		end
	end

endmodule

/* hw/exec_alu.sv */
module exec_alu (
	input  exec_pkg::alu_op    op,
	input  exec_pkg::word      a,
	input  exec_pkg::word      b,
	input  logic               c_in,
	output exec_pkg::word      q,
	output exec_pkg::psr_flags flags
);
	import exec_pkg::*;

	word         x, y;
	logic        cy, arith;
	logic [32:0] sum;

	// Adder operands, subtraction as x + ~y + 1
	always_comb begin
		x = a;
		y = b;
		cy = 1'b0;
		arith = 1'b1;
		unique case (op)
			ALU_SUB, ALU_CMP: begin
				y = ~b;
				cy = 1'b1;
			end
			ALU_RSB: begin
				x = b;
				y = ~a;
				cy = 1'b1;
			end
			ALU_ADD, ALU_CMN: ;
			ALU_ADC: cy = c_in;
			ALU_SBC: begin
				y = ~b;
				cy = c_in;
			end
			ALU_RSC: begin
				x = b;
				y = ~a;
				cy = c_in;
			end
			default: arith = 1'b0;
		endcase
	end

	assign sum = {1'b0, x} + {1'b0, y} + {32'd0, cy};

	always_comb begin
		unique case (op)
			ALU_AND, ALU_TST: q = a & b;
			ALU_EOR, ALU_TEQ: q = a ^ b;
			ALU_ORR:          q = a | b;
			ALU_MOV:          q = b;
			ALU_BIC:          q = a & ~b;
			ALU_MVN:          q = ~b;
			default:          q = sum[31:0];
		endcase

		flags.n = q[31];
		flags.z = q == '0;
		flags.c = arith ? sum[32] : c_in;  // Shifter carry for logical ops
		flags.v = arith && x[31] == y[31] && sum[31] != x[31];
	end

endmodule

/* hw/reg_file.sv */
module reg_file (
	input  logic              clk,
	input  logic              rst_n,
	input  exec_pkg::reg_num  ra,
	input  exec_pkg::reg_num  rb,
	input  exec_pkg::reg_num  rs,
	input  exec_pkg::wb_port  wb,
	output exec_pkg::word     ra_value,
	output exec_pkg::word     rb_value,
	output exec_pkg::word     rs_value
);
	import exec_pkg::*;

	word regs [16];

	always_ff @(posedge clk) begin
		if (!rst_n)
			regs <= '{default: '0};
		else if (wb.valid)
			regs[wb.rd] <= wb.value;
	end

	// Write-first, a same-cycle write is seen by the reader
	assign ra_value = (wb.valid && wb.rd == ra) ? wb.value : regs[ra];
	assign rb_value = (wb.valid && wb.rd == rb) ? wb.value : regs[rb];
	assign rs_value = (wb.valid && wb.rd == rs) ? wb.value : regs[rs];

endmodule

/* hw/ldst_reg_pop.sv */
module ldst_reg_pop (
	input  exec_pkg::reg_list regs,
	output logic              valid,
	output exec_pkg::reg_num  pop_lower,
	output exec_pkg::reg_num  pop_upper,
	output exec_pkg::reg_list next_lower,
	output exec_pkg::reg_list next_upper
);
	import exec_pkg::*;

	assign valid = |regs;

	always_comb begin
		pop_lower = '0;
		pop_upper = '0;

		// Last hit wins, so scan toward the wanted end
		for (int i = 15; i >= 0; i--)
			if (regs[i])
				pop_lower = reg_num'(i);
		for (int i = 0; i < 16; i++)
			if (regs[i])
				pop_upper = reg_num'(i);

		next_lower = regs;
		next_lower[pop_lower] = 1'b0;
		next_upper = regs;
		next_upper[pop_upper] = 1'b0;
	end

	always_comb begin
		if (valid)
			assert (pop_lower <= pop_upper);
	end

endmodule

/* hw/exec_control.sv */
`include "exec_settings.svh"

module exec_control (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     issue_valid,
	input  exec_pkg::insn_decode     dec,
	input  exec_pkg::ptr             pc,
	input  exec_pkg::psr_flags       flags,
	input  exec_pkg::word            ra_value,
	input  exec_pkg::word            rb_value,
	input  exec_pkg::word            rs_value,
	input  exec_pkg::word            shift_q,
	input  exec_pkg::word            alu_q,
	input  logic                     shift_c,
	input  exec_pkg::psr_flags       alu_flags,
	input  logic                     mem_ready,
	input  exec_pkg::word            mem_rdata,
	input  exec_pkg::reg_num         pop_lower,
	input  exec_pkg::reg_num         pop_upper,
	input  exec_pkg::reg_list        next_lower,
	input  exec_pkg::reg_list        next_upper,
	input  logic                     pop_valid,
	output logic                     stall,
	output exec_pkg::reg_num         ra,
	output exec_pkg::reg_num         rb,
	output exec_pkg::reg_num         rs,
	output exec_pkg::shifter_control shifter,
	output exec_pkg::word            shift_in,
	output exec_pkg::alu_op          alu,
	output exec_pkg::word            alu_a,
	output exec_pkg::word            alu_b,
	output logic                     c_in,
	output exec_pkg::wb_port         wb,
	output logic                     update_flags,
	output exec_pkg::psr_flags       wb_flags,
	output logic                     branch,
	output exec_pkg::ptr             branch_target,
	output logic                     mem_start,
	output exec_pkg::mem_req         mem_req,
	output exec_pkg::reg_list        mem_list
);
	import exec_pkg::*;

	ctrl_cycle  cycle;
	insn_decode d;
	ptr         pc_l;
	psr_flags   flags_l, cur_flags, pend_flags;
	word        saved_base, pend_value, pc_visible, rn_val, rm_val, rs_val;
	reg_num     xfer_rd, pend_rd, popped;
	reg_list    next_list;
	ptr         next_addr;
	logic       shifted_c, pend_wb, pend_upd, logical;

	assign stall = cycle != ISSUE;
	assign pc_visible = {pc_l, 2'b00} + `PC_AHEAD;

	assign popped = d.increment ? pop_lower : pop_upper;
	assign next_list = d.increment ? next_lower : next_upper;
	assign next_addr = d.pre_indexed ? alu_q[31:2] : alu_a[31:2];

	// Store data comes through the rs port during transfers
	assign ra = d.rn;
	assign rb = d.rm;
	assign rs = !d.ldst_enable ? d.rs : (d.block ? popped : d.rd);

	assign rn_val = ra == `R15 ? pc_visible : ra_value;
	assign rm_val = rb == `R15 ? pc_visible : rb_value;
	assign rs_val = rs == `R15 ? pc_visible : rs_value;

	// Flags still in flight from the previous instruction
	assign cur_flags = pend_upd ? pend_flags : (update_flags ? wb_flags : flags);

	always_comb begin
		unique case (d.op)
			ALU_AND, ALU_EOR, ALU_TST, ALU_TEQ,
			ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN: logical = 1'b1;
			default:                            logical = 1'b0;
		endcase
	end

	always_comb begin
		shift_in = d.snd_is_imm ? {20'b0, d.imm12} : rm_val;
		shifter.kind = d.shift;
		shifter.amount = {3'b000, d.shift_imm};
		shifter.c_in = flags_l.c;
		if ((d.shift == SHIFT_LSR || d.shift == SHIFT_ASR) && d.shift_imm == 5'd0)
			shifter.amount = 8'd32;
		if (d.snd_is_imm) begin
			shifter.kind = SHIFT_LSL;  // Immediate passes straight through
			shifter.amount = 8'd0;
		end

		unique case (cycle)
			REG_SHIFT: begin
				shift_in = rm_val;
				shifter.kind = d.shift;
				shifter.amount = rs_val[7:0];
			end
			EXECUTE: begin
				if (d.shift_by_reg && !d.snd_is_imm) begin
					shift_in = saved_base;
					shifter.kind = SHIFT_LSL;
					shifter.amount = 8'd0;
					shifter.c_in = shifted_c;
				end
			end
			default: ;
		endcase
	end

	always_comb begin
		alu = d.op;
		alu_a = rn_val;
		alu_b = shift_q;
		c_in = logical ? shift_c : flags_l.c;

		unique case (cycle)
			EXECUTE: begin
				if (d.ldst_enable) begin
					alu = d.increment ? ALU_ADD : ALU_SUB;
					if (d.block)
						alu_b = 32'd4;
				end
			end
			TRANSFER: begin
				alu = d.increment ? ALU_ADD : ALU_SUB;
				alu_a = saved_base;
				alu_b = 32'd4;
			end
			EXCEPTION: begin
				alu = ALU_ADD;  // Return address for R14
				alu_a = {pc_l, 2'b00};
				alu_b = 32'd4;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cycle <= ISSUE;
			wb <= '0;
			wb_flags <= '0;
			update_flags <= 1'b0;
			branch <= 1'b0;
			mem_start <= 1'b0;
			pend_wb <= 1'b0;
			pend_upd <= 1'b0;
		end else begin
			wb.valid <= 1'b0;
			update_flags <= 1'b0;
			branch <= 1'b0;
			mem_start <= 1'b0;

			unique case (cycle)
				ISSUE: begin
					wb.valid <= pend_wb;
					wb.rd <= pend_rd;
					wb.value <= pend_value;
					update_flags <= pend_upd;
					wb_flags <= pend_flags;
					pend_wb <= 1'b0;
					pend_upd <= 1'b0;

					if (issue_valid && dec.execute) begin
						d <= dec;
						pc_l <= pc;
						flags_l <= cur_flags;
						mem_list <= dec.regs;
						branch_target <= dec.undefined ? `EXC_UNDEF_VECTOR
							: pc + 30'd2 + {{6{dec.offset[23]}}, dec.offset};

						if (dec.undefined)
							cycle <= EXCEPTION;
						else if (dec.shift_by_reg && !dec.snd_is_imm && !dec.is_branch
							&& !dec.ldst_enable)
							cycle <= REG_SHIFT;
						else
							cycle <= EXECUTE;
					end
				end

				REG_SHIFT: begin
					saved_base <= shift_q;
					shifted_c <= shift_c;
					cycle <= EXECUTE;
				end

				EXECUTE: begin
					if (d.is_branch) begin
						branch <= 1'b1;
						cycle <= ISSUE;
					end else if (d.ldst_enable) begin
						mem_start <= !d.block || pop_valid;
						mem_req.addr <= next_addr;
						mem_req.wdata <= rs_val;
						mem_req.write <= !d.load;
						saved_base <= (d.block && !pop_valid) ? alu_a : alu_q;
						xfer_rd <= d.block ? popped : d.rd;
						mem_list <= d.block ? next_list : '0;  // Single transfer has no list

						if (!d.block || pop_valid)
							cycle <= TRANSFER;
						else
							cycle <= d.base_writeback ? BASE_WRITEBACK : ISSUE;
					end else begin
						pend_wb <= d.writeback;
						pend_upd <= d.update_flags;
						pend_rd <= d.rd;
						pend_value <= alu_q;
						// Logical ops leave V alone
						pend_flags <= '{n: alu_flags.n, z: alu_flags.z, c: alu_flags.c,
							v: logical ? flags_l.v : alu_flags.v};
						cycle <= ISSUE;
					end
				end

				TRANSFER: begin
					if (mem_ready) begin
						wb.valid <= !mem_req.write;
						wb.rd <= xfer_rd;
						wb.value <= mem_rdata;

						if (pop_valid) begin
							mem_start <= 1'b1;
							mem_req.addr <= next_addr;
							mem_req.wdata <= rs_val;
							saved_base <= alu_q;
							xfer_rd <= popped;
							mem_list <= next_list;
						end else
							cycle <= d.base_writeback ? BASE_WRITEBACK : ISSUE;
					end
				end

				BASE_WRITEBACK: begin
					wb.valid <= 1'b1;
					wb.rd <= d.rn;
					wb.value <= saved_base;
					cycle <= ISSUE;
				end

				EXCEPTION: begin
					wb.valid <= 1'b1;
					wb.rd <= `R15;
					wb.value <= {`EXC_UNDEF_VECTOR, 2'b00};
					branch <= 1'b1;
					pend_wb <= 1'b1;  // R14 follows one cycle later
					pend_rd <= `R14;
					pend_value <= alu_q;
					pend_upd <= 1'b0;
					cycle <= ISSUE;
				end

				default: cycle <= ISSUE;
			endcase
		end
	end

	// Request must not move while memory has not answered
	assert property (@(posedge clk) disable iff (!rst_n)
		cycle == TRANSFER && !mem_ready |=> $stable(mem_req));

	// Memory answers only while a request is open
	assert property (@(posedge clk) disable iff (!rst_n)
		mem_ready |-> cycle == TRANSFER);

endmodule

/* hw/exec_core.sv */
module exec_core (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 issue_valid,
	input  exec_pkg::insn_decode dec,
	input  exec_pkg::ptr         pc,
	input  logic                 mem_ready,
	input  exec_pkg::word        mem_rdata,
	output logic                 stall,
	output exec_pkg::wb_port     wb,
	output exec_pkg::psr_flags   flags,
	output logic                 branch,
	output exec_pkg::ptr         branch_target,
	output logic                 mem_start,
	output exec_pkg::mem_req     mem_req
);
	import exec_pkg::*;

	reg_num         ra, rb, rs, pop_lower, pop_upper;
	word            ra_value, rb_value, rs_value, shift_in, shift_q, alu_a, alu_b, alu_q;
	shifter_control shifter;
	alu_op          alu;
	psr_flags       alu_flags, wb_flags;
	reg_list        mem_list, next_lower, next_upper;
	logic           shift_c, c_in, update_flags, pop_valid;

	always_ff @(posedge clk) begin
		if (!rst_n)
			flags <= '0;
		else if (update_flags)
			flags <= wb_flags;
	end

	exec_control i_exec_control (.*);

	barrel_shifter i_barrel_shifter (
		.value(shift_in),
		.ctrl(shifter),
		.q(shift_q),
		.c_out(shift_c)
	);

	exec_alu i_exec_alu (
		.op(alu),
		.a(alu_a),
		.b(alu_b),
		.c_in,
		.q(alu_q),
		.flags(alu_flags)
	);

	reg_file i_reg_file (.*);

	ldst_reg_pop i_ldst_reg_pop (
		.regs(mem_list),
		.valid(pop_valid),
		.pop_lower,
		.pop_upper,
		.next_lower,
		.next_upper
	);

endmodule

/* bench/exec_core_tb.sv */
`include "exec_settings.svh"

module exec_core_tb;
	import exec_pkg::*;

	localparam int N_RANDOM = 60;
	localparam int TIMEOUT = N_RANDOM * 80;

	logic       clk = 1'b0;
	logic       rst_n, issue_valid, mem_ready, stall, branch, mem_start;
	insn_decode dec;
	ptr         pc, branch_target, next_pc;
	word        mem_rdata;
	wb_port     wb;
	psr_flags   flags, ref_flags;
	mem_req     mem_bus, held;

	word      ref_regs [16];
	word      ref_mem [ptr];
	word      dut_mem [ptr];
	wb_port   exp_wb [$];
	ptr       exp_branch [$];
	mem_req   exp_mem [$];
	psr_flags exp_flags [$];
	int err_wb, err_branch, err_mem, err_flags, err_other, cycles, wait_left;
	logic busy;

	exec_core i_exec_core (
		.clk, .rst_n, .issue_valid, .dec, .pc, .mem_ready, .mem_rdata,
		.stall, .wb, .flags, .branch, .branch_target, .mem_start,
		.mem_req(mem_bus)
	);

	always #10 clk = ~clk;

	// Memory contents before any store
	function automatic word fill_word(input ptr a);
		return {a, 2'b01} ^ 32'h5a3c_96e1 ^ {a[14:0], a[29:13]};
	endfunction

	function automatic word ref_read(input reg_num r, input ptr ipc);
		return r == `R15 ? {ipc, 2'b00} + `PC_AHEAD : ref_regs[r];
	endfunction

	function automatic void expect_write(input reg_num r, input word v);
		wb_port w;
		w.valid = 1'b1;
		w.rd = r;
		w.value = v;
		exp_wb.push_back(w);
		ref_regs[r] = v;
	endfunction

	function automatic void expect_mem(input word a, input word data, input logic write);
		mem_req m;
		m.addr = a[31:2];
		m.wdata = data;
		m.write = write;
		exp_mem.push_back(m);
	endfunction

	// ARM shift rules
	function automatic word ref_shift(input shift_kind k, input word v, input int n,
		input logic cin, output logic cout);
		word r;
		int m;
		r = v;
		cout = cin;
		if (n != 0) begin
			case (k)
				SHIFT_LSL: begin
					r = n < 32 ? v << n : '0;
					cout = n < 32 ? v[32 - n] : (n == 32 ? v[0] : 1'b0);
				end
				SHIFT_LSR: begin
					r = n < 32 ? v >> n : '0;
					cout = n < 32 ? v[n - 1] : (n == 32 ? v[31] : 1'b0);
				end
				SHIFT_ASR: begin
					r = n < 32 ? word'($signed(v) >>> n) : {32{v[31]}};
					cout = n < 32 ? v[n - 1] : v[31];
				end
				default: begin
					m = n % 32;
					r = m == 0 ? v : (v >> m) | (v << (32 - m));
					cout = r[31];
				end
			endcase
		end
		return r;
	endfunction

	function automatic void ref_alu(input alu_op op, input word a, input word b,
		input logic sc, input psr_flags old, output word q, output psr_flags f);
		logic [32:0] t;
		word x, y;
		logic borrow;
		f = old;
		f.c = sc;  // Logical ops take the shifter carry
		case (op)
			ALU_AND, ALU_TST: q = a & b;
			ALU_EOR, ALU_TEQ: q = a ^ b;
			ALU_ORR:          q = a | b;
			ALU_MOV:          q = b;
			ALU_BIC:          q = a & ~b;
			ALU_MVN:          q = ~b;
			ALU_ADD, ALU_CMN, ALU_ADC: begin
				t = {1'b0, a} + {1'b0, b} + {32'd0, op == ALU_ADC && old.c};
				q = t[31:0];
				f.c = t[32];
				f.v = a[31] == b[31] && q[31] != a[31];
			end
			default: begin
				x = (op == ALU_RSB || op == ALU_RSC) ? b : a;
				y = (op == ALU_RSB || op == ALU_RSC) ? a : b;
				borrow = (op == ALU_SBC || op == ALU_RSC) && !old.c;
				t = {1'b0, x} - {1'b0, y} - {32'd0, borrow};
				q = t[31:0];
				f.c = !t[32];  // Carry means no borrow
				f.v = x[31] != y[31] && q[31] != x[31];
			end
		endcase
		f.n = q[31];
		f.z = q == '0;
	endfunction

	function automatic word ref_load(input ptr a);
		return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
	endfunction

	function automatic void ref_exec(input insn_decode d, input ptr ipc);
		word op2, base, addr, q;
		logic sc;
		psr_flags f;
		int n, k;
		reg_num r;
		if (!d.execute)
			return;
		if (d.undefined) begin
			expect_write(`R15, {`EXC_UNDEF_VECTOR, 2'b00});
			expect_write(`R14, {ipc, 2'b00} + 32'd4);
			exp_branch.push_back(`EXC_UNDEF_VECTOR);
			return;
		end
		if (d.is_branch) begin
			exp_branch.push_back(ipc + 30'd2 + 30'($signed(d.offset)));
			return;
		end
		sc = ref_flags.c;
		n = d.shift_imm;
		if ((d.shift == SHIFT_LSR || d.shift == SHIFT_ASR) && n == 0)
			n = 32;
		if (d.snd_is_imm)
			op2 = {20'b0, d.imm12};
		else if (d.shift_by_reg && !d.ldst_enable)
			op2 = ref_shift(d.shift, ref_read(d.rm, ipc),
				int'(ref_read(d.rs, ipc) & 32'hff), ref_flags.c, sc);
		else
			op2 = ref_shift(d.shift, ref_read(d.rm, ipc), n, ref_flags.c, sc);
		base = ref_read(d.rn, ipc);
		if (d.ldst_enable && !d.block) begin
			q = d.increment ? base + op2 : base - op2;
			addr = d.pre_indexed ? q : base;
			expect_mem(addr, ref_read(d.rd, ipc), !d.load);
			if (d.load)
				expect_write(d.rd, ref_load(addr[31:2]));
			else
				ref_mem[addr[31:2]] = ref_read(d.rd, ipc);
			if (d.base_writeback)
				expect_write(d.rn, q);
		end else if (d.ldst_enable) begin
			k = 0;
			for (int i = 0; i < 16; i++) begin
				r = d.increment ? reg_num'(i) : reg_num'(15 - i);
				if (d.regs[r]) begin
					k++;
					n = d.pre_indexed ? 4 * k : 4 * (k - 1);
					addr = d.increment ? base + word'(n) : base - word'(n);
					expect_mem(addr, ref_read(r, ipc), !d.load);
					if (d.load)
						expect_write(r, ref_load(addr[31:2]));
					else
						ref_mem[addr[31:2]] = ref_read(r, ipc);
				end
			end
			if (d.base_writeback)
				expect_write(d.rn, d.increment ? base + word'(4 * k) : base - word'(4 * k));
		end else begin
			ref_alu(d.op, base, op2, sc, ref_flags, q, f);
			if (d.writeback)
				expect_write(d.rd, q);
			if (d.update_flags) begin
				ref_flags = f;
				exp_flags.push_back(f);
			end
		end
	endfunction

	task automatic check_wb(input wb_port exp, input wb_port got);
		if (got !== exp) begin
			err_wb++;
			$display("error wb: expected rd %h value %h, got rd %h value %h",
				exp.rd, exp.value, got.rd, got.value);
		end
	endtask

	task automatic check_branch(input ptr exp, input ptr got);
		if (got !== exp) begin
			err_branch++;
			$display("error branch_target: expected %h, got %h", exp, got);
		end
	endtask

	// Write data matters only for stores
	task automatic check_mem(input mem_req exp, input mem_req got);
		if (got.addr !== exp.addr || got.write !== exp.write
			|| (exp.write && got.wdata !== exp.wdata)) begin
			err_mem++;
			$display("error mem_req: expected addr %h wdata %h write %h, got %h %h %h",
				exp.addr, exp.wdata, exp.write, got.addr, got.wdata, got.write);
		end
	endtask

	task automatic check_flags(input psr_flags exp, input psr_flags got);
		if (got !== exp) begin
			err_flags++;
			$display("error flags: expected %h, got %h", exp, got);
		end
	endtask

	always @(negedge clk) begin
		if (rst_n) begin
			if (wb.valid && exp_wb.size() == 0) begin
				err_other++;
				$display("register write to r%0d came with nothing expected", wb.rd);
			end else if (wb.valid)
				check_wb(exp_wb.pop_front(), wb);
			if (branch && exp_branch.size() == 0) begin
				err_other++;
				$display("branch pulse came with nothing expected");
			end else if (branch)
				check_branch(exp_branch.pop_front(), branch_target);
			if (mem_start && exp_mem.size() == 0) begin
				err_other++;
				$display("memory request came with nothing expected");
			end else if (mem_start)
				check_mem(exp_mem.pop_front(), mem_bus);
			if (i_exec_core.update_flags && exp_flags.size() == 0) begin
				err_other++;
				$display("flags update came with nothing expected");
			end else if (i_exec_core.update_flags)
				check_flags(exp_flags.pop_front(), i_exec_core.wb_flags);
		end
	end

	// Memory answers each request after a random delay
	always @(negedge clk) begin
		mem_ready = 1'b0;
		if (!rst_n)
			busy = 1'b0;
		else begin
			if (mem_start) begin
				if (busy) begin
					err_other++;
					$display("new memory request while one was still open");
				end
				busy = 1'b1;
				held = mem_bus;
				wait_left = $urandom % 4;
			end
			if (busy && wait_left == 0) begin
				busy = 1'b0;
				mem_ready = 1'b1;
				mem_rdata = dut_mem.exists(held.addr) ? dut_mem[held.addr] : fill_word(held.addr);
				if (held.write)
					dut_mem[held.addr] = held.wdata;
			end else if (busy)
				wait_left--;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("run did not finish within %0d cycles", TIMEOUT);
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic issue(input insn_decode d);
		while (stall)
			@(negedge clk);
		ref_exec(d, next_pc);
		dec = d;
		pc = next_pc;
		issue_valid = 1'b1;
		@(negedge clk);
		issue_valid = 1'b0;
		next_pc++;
	endtask

	function automatic insn_decode data_op(input alu_op op, input reg_num rd, input reg_num rm,
		input logic [11:0] imm, input logic use_imm);
		insn_decode d;
		d = '0;
		d.execute = 1'b1;
		d.op = op;
		d.rd = rd;
		d.rm = rm;
		d.imm12 = imm;
		d.snd_is_imm = use_imm;
		d.writeback = 1'b1;
		return d;
	endfunction

	// r1 to r3 keep shift amounts of 32, 256 and 33
	function automatic reg_num pick_dest();
		reg_num r;
		r = 4'($urandom % 13);
		return r == 0 ? r : r + 4'd3;
	endfunction

	function automatic insn_decode random_insn();
		insn_decode d;
		int kind;
		d = data_op(alu_op'(4'($urandom)), pick_dest(), 4'($urandom), 12'($urandom), 1'b0);
		d.rn = 4'($urandom);
		d.rs = 4'($urandom);
		d.shift = shift_kind'(2'($urandom));
		d.shift_imm = 5'($urandom);
		kind = $urandom % 16;
		if (kind < 6) begin
			d.snd_is_imm = kind < 2;
			d.shift_by_reg = kind >= 4;
			if (d.shift_by_reg && $urandom % 2)
				d.rs = 4'(1 + $urandom % 3);
			d.writeback = !(d.op inside {ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN});
			d.update_flags = !d.writeback || 1'($urandom);
		end else begin
			d.writeback = 1'b0;
			if (kind < 8) begin
				d.is_branch = 1'b1;
				d.offset = 24'($urandom);
			end else if (kind < 13) begin
				d.ldst_enable = 1'b1;
				d.snd_is_imm = 1'($urandom);
				d.load = 1'($urandom);
				d.pre_indexed = 1'($urandom);
				d.increment = 1'($urandom);
				d.base_writeback = 1'($urandom);
				d.rn = pick_dest();
				d.block = kind >= 11;
				d.regs = 16'($urandom);
				if (d.load)
					d.regs &= 16'hfff1;
			end else if (kind == 13)
				d.undefined = 1'b1;
			else begin
				d.execute = 1'b0;  // Should leave no trace
				d.writeback = 1'b1;
				d.update_flags = 1'b1;
			end
		end
		return d;
	endfunction

	initial begin
		void'($urandom(54));
		rst_n = 1'b0;
		issue_valid = 1'b0;
		dec = '0;
		pc = '0;
		mem_ready = 1'b0;
		mem_rdata = '0;
		next_pc = 30'h100;
		ref_flags = '0;
		ref_regs = '{default: '0};
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		if (stall || branch || mem_start || wb.valid) begin
			err_other++;
			$display("outputs were not idle after reset");
		end
		check_flags('0, flags);

		issue(data_op(ALU_MOV, 4'd1, 4'd0, 12'd32, 1'b1));
		issue(data_op(ALU_MOV, 4'd2, 4'd0, 12'd256, 1'b1));
		issue(data_op(ALU_MOV, 4'd3, 4'd0, 12'd33, 1'b1));
		for (int i = 0; i < 13; i++)
			issue(data_op(i % 2 ? ALU_MVN : ALU_MOV, i == 0 ? 4'd0 : 4'(i + 3), 4'd0,
				12'($urandom), 1'b1));
		for (int i = 0; i < N_RANDOM; i++)
			issue(random_insn());
		// Read every register back through the write port
		for (int i = 0; i < 15; i++)
			issue(data_op(ALU_MOV, 4'(i), 4'(i), 12'd0, 1'b0));

		while (stall || exp_wb.size() != 0 || exp_mem.size() != 0
			|| exp_branch.size() != 0 || exp_flags.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		check_flags(ref_flags, flags);

		$display("errors: wb %0d, branch %0d, mem %0d, flags %0d, other %0d",
			err_wb, err_branch, err_mem, err_flags, err_other);
		if (err_wb + err_branch + err_mem + err_flags + err_other == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* sources.f */
+incdir+hw
hw/exec_pkg.sv
hw/barrel_shifter.sv
hw/exec_alu.sv
hw/reg_file.sv
hw/ldst_reg_pop.sv
hw/exec_control.sv
hw/exec_core.sv
bench/exec_core_tb.sv

/* run_sim.sh */
#!/bin/bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module exec_core_tb -Mdir obj_dir

./obj_dir/Vexec_core_tb | tee sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi

echo "simulation passed"
